/* logic/banked_memory.sv */
`default_nettype none

module banked_memory
   import mem_sys_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  mem_req_t req,
   output logic     stall,
   output word_t    rd_data,
   output logic     rd_valid
);

   // Word interleaved, one row holds a word per bank
   word_t                      banks [NUM_BANKS][2**(ADDR_W-OFFSET_W)];
   logic [BUSY_W-1:0]          busy_cnt [NUM_BANKS];
   logic [MEM_READ_LAT-1:0]    vld_pipe;
   word_t                      data_pipe [MEM_READ_LAT];
   bank_t                      bank;
   logic [ADDR_W-OFFSET_W-1:0] row;
   logic                       access;
   logic                       accept;

   assign bank   = req.addr[OFFSET_W-1:1];
   assign row    = req.addr[ADDR_W-1:OFFSET_W];
   assign access = req.rd | req.wr;
   assign stall  = access & (busy_cnt[bank] != '0);   // Refused, caller retries
   assign accept = access & ~stall;

   // Per-bank busy countdown
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            if (accept && bank == bank_t'(b)) begin
               busy_cnt[b] <= BUSY_W'(BANK_BUSY);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && req.wr) begin
         banks[bank][row] <= req.data;
      end
   end

   // Read return pipeline
   always_ff @(posedge clk) begin
      data_pipe[0] <= banks[bank][row];
      for (int s = 1; s < MEM_READ_LAT; s++) begin
         data_pipe[s] <= data_pipe[s-1];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_pipe <= '0;
      end else begin
         vld_pipe <= {vld_pipe[MEM_READ_LAT-2:0], accept & req.rd};
      end
   end

   assign rd_data  = data_pipe[MEM_READ_LAT-1];
   assign rd_valid = vld_pipe[MEM_READ_LAT-1];

endmodule

`default_nettype wire

/* logic/cache_controller.sv */
`default_nettype none

module cache_controller
   import mem_sys_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  cache_req_t  req,
   input  way_status_t sel_status,
   input  logic        mem_stall,
   input  logic        mem_rd_valid,
   output way_ctrl_t   way_ctrl,
   output mem_req_t    mem_req,
   output logic        lock,
   output logic        touch,
   output logic        done,
   output logic        stall,
   output logic        cache_hit,
   output logic        err
);

   ctrl_state_t state;
   ctrl_state_t state_nxt;
   bank_t       iss_cnt;     // Next word to send to memory
   bank_t       ret_cnt;     // Next fill word to come back
   logic        first_cmp;   // Compare not yet tried for this access
   logic        err_q;
   logic        bad_req;
   logic        first_hit;
   offset_t     byte_off;
   index_t      idx;

   assign byte_off  = req.addr[OFFSET_W-1:0];
   assign idx       = req.addr[OFFSET_W +: INDEX_W];
   assign bad_req   = (req.rd & req.wr) | byte_off[0];   // Conflict or misaligned
   assign first_hit = (state == COMP) & first_cmp & sel_status.hit;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (req.rd | req.wr) begin
               state_nxt = bad_req ? FINISH : COMP;
            end
         end
         COMP: begin
            if (sel_status.hit) begin
               state_nxt = first_cmp ? IDLE : FINISH;
            end else if (sel_status.valid & sel_status.dirty) begin
               state_nxt = WB;
            end else begin
               state_nxt = FILL;
            end
         end
         WB: begin
            if (!mem_stall && iss_cnt == 2'd3) begin
               state_nxt = FILL;
            end
         end
         FILL: begin
            if (!mem_stall && iss_cnt == 2'd3) begin
               state_nxt = REFILL_DONE;
            end
         end
         REFILL_DONE: begin
            if (mem_rd_valid && ret_cnt == 2'd3) begin
               state_nxt = COMP;   // Retry, now hits
            end
         end
         FINISH: state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   // Way and memory commands
   always_comb begin
      way_ctrl = '0;
      mem_req  = '0;
      case (state)
         COMP: begin
            way_ctrl.comp     = 1'b1;
            way_ctrl.write    = req.wr & sel_status.hit;
            way_ctrl.valid_in = 1'b1;
            way_ctrl.offset   = req.addr[OFFSET_W-1:1];
         end
         WB: begin
            way_ctrl.offset = iss_cnt;   // Victim word being written back
            mem_req.wr      = 1'b1;
            mem_req.addr    = {sel_status.tag, idx, iss_cnt, 1'b0};
            mem_req.data    = sel_status.data;
         end
         FILL, REFILL_DONE: begin
            way_ctrl.write    = mem_rd_valid;
            way_ctrl.valid_in = 1'b1;
            way_ctrl.fill     = 1'b1;
            way_ctrl.offset   = ret_cnt;
            mem_req.rd        = (state == FILL);
            mem_req.addr      = {req.addr[ADDR_W-1:OFFSET_W], iss_cnt, 1'b0};
         end
         FINISH: begin
            way_ctrl.offset = req.addr[OFFSET_W-1:1];   // Requested word on data_out
         end
         default: begin
            way_ctrl = '0;
            mem_req  = '0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= IDLE;
         iss_cnt   <= '0;
         ret_cnt   <= '0;
         first_cmp <= 1'b0;
         err_q     <= 1'b0;
      end else begin
         state <= state_nxt;
         if (state == IDLE) begin
            first_cmp <= 1'b1;
            err_q     <= bad_req;
         end
         if (state == COMP) begin
            first_cmp <= 1'b0;
         end
         // Counters wrap back to zero after a whole line
         if ((state == WB || state == FILL) && !mem_stall) begin
            iss_cnt <= iss_cnt + 1'b1;
         end
         if ((state == FILL || state == REFILL_DONE) && mem_rd_valid) begin
            ret_cnt <= ret_cnt + 1'b1;
         end
      end
   end

   assign done      = first_hit | (state == FINISH);
   assign cache_hit = first_hit;
   assign err       = (state == FINISH) & err_q;
   assign stall     = (state != IDLE) & ~done;
   assign lock      = (state == COMP) & first_cmp;
   assign touch     = done & ~err;   // Error leaves LRU alone

endmodule

`default_nettype wire

/* logic/cache_way.sv */
`default_nettype none

module cache_way
   import mem_sys_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  addr_t       addr,
   input  way_ctrl_t   ctrl,
   input  word_t       client_data,
   input  word_t       fill_data,
   output way_status_t status
);

   tag_t                tag_q  [NUM_SETS];
   word_t               data_q [NUM_SETS][WORDS_PER_LINE];
   logic [NUM_SETS-1:0] valid_q;
   logic [NUM_SETS-1:0] dirty_q;
   index_t              index;
   tag_t                tag;

   assign index = addr[OFFSET_W +: INDEX_W];
   assign tag   = addr[ADDR_W-1 -: TAG_W];

   // Line status bits
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (ctrl.write) begin
         valid_q[index] <= ctrl.valid_in;
         if (ctrl.fill) begin
            dirty_q[index] <= 1'b0;   // Clean copy of memory
         end else if (ctrl.comp) begin
            dirty_q[index] <= 1'b1;   // Client write
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl.write) begin
         data_q[index][ctrl.offset] <= ctrl.fill ? fill_data : client_data;
         if (ctrl.fill) begin
            tag_q[index] <= tag;
         end
      end
   end

   // Combinational lookup
   assign status.hit   = ctrl.comp & valid_q[index] & (tag_q[index] == tag);
   assign status.valid = valid_q[index];
   assign status.dirty = dirty_q[index];
   assign status.tag   = tag_q[index];
   assign status.data  = data_q[index][ctrl.offset];

endmodule

`default_nettype wire

/* logic/mem_sys_pkg.sv */
`default_nettype none

package mem_sys_pkg;

   // Address split and line geometry
   localparam int ADDR_W         = 16;
   localparam int WORD_W         = 16;
   localparam int TAG_W          = 5;
   localparam int INDEX_W        = 8;
   localparam int OFFSET_W       = 3;
   localparam int WORDS_PER_LINE = 4;
   localparam int NUM_SETS       = 256;
   localparam int NUM_BANKS      = 4;

   // Main memory timing
   localparam int MEM_READ_LAT = 2;   // Accepted read to data
   localparam int BANK_BUSY    = 4;   // Busy cycles after an access
   localparam int BUSY_W       = $clog2(BANK_BUSY + 1);

   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [WORD_W-1:0]   word_t;
   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [INDEX_W-1:0]  index_t;
   typedef logic [OFFSET_W-1:0] offset_t;
   typedef logic [1:0]          bank_t;   // Bank, or word within a line

   typedef struct packed {
      addr_t addr;
      word_t data;
      logic  rd;
      logic  wr;
   } cache_req_t;

   typedef struct packed {
      logic  comp;       // Compare mode
      logic  write;
      logic  valid_in;
      bank_t offset;     // Word in the line
      logic  fill;       // Memory data instead of client data
   } way_ctrl_t;

   typedef struct packed {
      logic  hit;
      logic  valid;
      logic  dirty;
      tag_t  tag;
      word_t data;
   } way_status_t;

   typedef struct packed {
      addr_t addr;
      word_t data;
      logic  rd;
      logic  wr;
   } mem_req_t;

   typedef enum logic [2:0] {
      IDLE,
      COMP,
      WB,
      FILL,
      REFILL_DONE,
      FINISH
   } ctrl_state_t;

endpackage

`default_nettype wire

/* logic/mem_system.sv */
`default_nettype none

module mem_system
   import mem_sys_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  cache_req_t req,
   output word_t      data_out,
   output logic       done,
   output logic       stall,
   output logic       cache_hit,
   output logic       err
);

   way_ctrl_t   way_ctrl;
   way_ctrl_t   way0_ctrl;
   way_ctrl_t   way1_ctrl;
   way_status_t status0;
   way_status_t status1;
   way_status_t sel_status;
   mem_req_t    mem_req;
   word_t       mem_rd_data;
   logic        mem_stall;
   logic        mem_rd_valid;
   logic        lock;
   logic        touch;
   logic        write0;
   logic        write1;

   // Same command to both ways, write strobe steered by the selector
   assign way0_ctrl = '{comp: way_ctrl.comp, write: write0, valid_in: way_ctrl.valid_in,
                        offset: way_ctrl.offset, fill: way_ctrl.fill};
   assign way1_ctrl = '{comp: way_ctrl.comp, write: write1, valid_in: way_ctrl.valid_in,
                        offset: way_ctrl.offset, fill: way_ctrl.fill};
   assign data_out  = sel_status.data;

   cache_controller u_ctrl (
      .clk          (clk),
      .arst_n       (arst_n),
      .req          (req),
      .sel_status   (sel_status),
      .mem_stall    (mem_stall),
      .mem_rd_valid (mem_rd_valid),
      .way_ctrl     (way_ctrl),
      .mem_req      (mem_req),
      .lock         (lock),
      .touch        (touch),
      .done         (done),
      .stall        (stall),
      .cache_hit    (cache_hit),
      .err          (err)
   );

   cache_way u_way0 (
      .clk         (clk),
      .arst_n      (arst_n),
      .addr        (req.addr),
      .ctrl        (way0_ctrl),
      .client_data (req.data),
      .fill_data   (mem_rd_data),
      .status      (status0)
   );

   cache_way u_way1 (
      .clk         (clk),
      .arst_n      (arst_n),
      .addr        (req.addr),
      .ctrl        (way1_ctrl),
      .client_data (req.data),
      .fill_data   (mem_rd_data),
      .status      (status1)
   );

   way_select u_sel (
      .clk        (clk),
      .arst_n     (arst_n),
      .index      (req.addr[OFFSET_W +: INDEX_W]),
      .status0    (status0),
      .status1    (status1),
      .lock       (lock),
      .touch      (touch),
      .write_req  (way_ctrl.write),
      .write0     (write0),
      .write1     (write1),
      .sel_status (sel_status)
   );

   banked_memory u_mem (
      .clk      (clk),
      .arst_n   (arst_n),
      .req      (mem_req),
      .stall    (mem_stall),
      .rd_data  (mem_rd_data),
      .rd_valid (mem_rd_valid)
   );

endmodule

`default_nettype wire

/* logic/way_select.sv */
`default_nettype none

module way_select
   import mem_sys_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  index_t      index,
   input  way_status_t status0,
   input  way_status_t status1,
   input  logic        lock,
   input  logic        touch,
   input  logic        write_req,
   output logic        write0,
   output logic        write1,
   output way_status_t sel_status
);

   logic [NUM_SETS-1:0] lru_q;   // Names the least recently used way
   logic                victim;
   logic                choice;
   logic                way_q;
   logic                sel_way;

   always_comb begin
      if (!status0.valid) begin
         victim = 1'b0;
      end else if (!status1.valid) begin
         victim = 1'b1;
      end else begin
         victim = lru_q[index];
      end
   end

   assign choice  = status0.hit ? 1'b0 : (status1.hit ? 1'b1 : victim);
   assign sel_way = lock ? choice : way_q;   // Live choice while locking

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         way_q <= 1'b0;
         lru_q <= '0;
      end else begin
         if (lock) begin
            way_q <= choice;
         end
         if (touch) begin
            lru_q[index] <= ~sel_way;   // Other way becomes LRU
         end
      end
   end

   assign write0     = write_req & ~sel_way;
   assign write1     = write_req & sel_way;
   assign sel_status = sel_way ? status1 : status0;

endmodule

`default_nettype wire

/* tb.f */
logic/mem_sys_pkg.sv
logic/cache_way.sv
logic/banked_memory.sv
logic/way_select.sv
logic/cache_controller.sv
logic/mem_system.sv
tests/mem_system_tb.sv

/* tests/mem_system_tb.sv */
`default_nettype none

module mem_system_tb
   import mem_sys_pkg::*;
();

   localparam int DONE_LIMIT = 30;   // Cycles allowed for one access
   localparam int WD_CYCLES  = 40;   // Watchdog budget per entry
   localparam int HALF_CLK   = 5;
   localparam int NUM_WORDS  = 2**(ADDR_W-1);

   logic       clk;
   logic       arst_n;
   cache_req_t req;
   word_t      data_out;
   logic       done;
   logic       stall;
   logic       cache_hit;
   logic       err;

   // Stimulus table, one slot per entry
   string      names    [$];
   cache_req_t reqs     [$];
   logic       exp_hits [$];
   logic       exp_errs [$];
   logic       table_ready;

   // Reference cache model and flat word store
   logic       m_valid [2][NUM_SETS];
   tag_t       m_tag   [2][NUM_SETS];
   logic       m_lru   [NUM_SETS];   // Least recently used way
   word_t      m_word  [NUM_WORDS];
   logic       m_known [NUM_WORDS];

   int         err_count   = 0;
   int         clean_count = 0;
   int         bad_count   = 0;

   mem_system u_mem_system (
      .clk       (clk),
      .arst_n    (arst_n),
      .req       (req),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #HALF_CLK clk = ~clk;
   end

   // Tag, set, word in line, byte 0
   function automatic addr_t make_addr(input tag_t t, input index_t s, input bank_t w);
      return {t, s, w, 1'b0};
   endfunction

   task automatic add_entry(input string name, input logic rd, input logic wr, input addr_t a,
                            input logic hit, input logic bad);
      cache_req_t r;
      r.addr = a;
      r.data = word_t'($urandom);
      r.rd   = rd;
      r.wr   = wr;
      names.push_back(name);
      reqs.push_back(r);
      exp_hits.push_back(hit);
      exp_errs.push_back(bad);
   endtask

   task automatic build_table();
      addr_t  rnd_addr [6];
      index_t s;
      s = 8'h40;
      add_entry("rd_cold", 1, 0, make_addr(5'd4, 8'h05, 2'd0), 0, 0);
      add_entry("wr_miss", 0, 1, make_addr(5'd1, 8'h21, 2'd2), 0, 0);
      add_entry("rd_same", 1, 0, make_addr(5'd1, 8'h21, 2'd2), 1, 0);
      add_entry("rd_line", 1, 0, make_addr(5'd1, 8'h21, 2'd3), 1, 0);
      // Tags 1, 2 and 3 fight over set 0x40
      add_entry("wr_a", 0, 1, make_addr(5'd1, s, 2'd0), 0, 0);
      add_entry("wr_b", 0, 1, make_addr(5'd2, s, 2'd0), 0, 0);
      add_entry("rd_a", 1, 0, make_addr(5'd1, s, 2'd0), 1, 0);
      add_entry("rd_b", 1, 0, make_addr(5'd2, s, 2'd0), 1, 0);
      add_entry("wr_c", 0, 1, make_addr(5'd3, s, 2'd2), 0, 0);      // Evicts dirty A
      add_entry("rd_b_kept", 1, 0, make_addr(5'd2, s, 2'd0), 1, 0);
      add_entry("rd_a_back", 1, 0, make_addr(5'd1, s, 2'd0), 0, 0); // Evicts dirty C
      add_entry("rd_b_again", 1, 0, make_addr(5'd2, s, 2'd0), 1, 0);
      add_entry("rd_c_back", 1, 0, make_addr(5'd3, s, 2'd2), 0, 0);
      // Rejected requests leave the cache alone
      add_entry("misaligned_rd", 1, 0, make_addr(5'd1, s, 2'd0) | 16'h0001, 0, 1);
      add_entry("misaligned_wr", 0, 1, make_addr(5'd2, s, 2'd0) | 16'h0001, 0, 1);
      add_entry("rd_wr_conflict", 1, 1, make_addr(5'd2, s, 2'd0), 0, 1);
      add_entry("rd_after_err", 1, 0, make_addr(5'd2, s, 2'd0), 1, 0);
      for (int k = 0; k < 6; k++) begin
         rnd_addr[k] = make_addr(tag_t'($urandom), index_t'(8'h80 + k), bank_t'($urandom));
         add_entry($sformatf("rnd_wr%0d", k), 0, 1, rnd_addr[k], 0, 0);
         if (k > 0) begin
            add_entry($sformatf("rnd_rd%0d", k - 1), 1, 0, rnd_addr[k-1], 1, 0);
         end
      end
      add_entry("rnd_rd5", 1, 0, rnd_addr[5], 1, 0);
   endtask

   task automatic model_clear();
      for (int s = 0; s < NUM_SETS; s++) begin
         m_valid[0][s] = 1'b0;
         m_valid[1][s] = 1'b0;
         m_lru[s]      = 1'b0;
      end
      for (int w = 0; w < NUM_WORDS; w++) begin
         m_known[w] = 1'b0;
      end
   endtask

   // Hit prediction with the victim rule, then the access itself
   task automatic model_access(input cache_req_t r, output logic hit, output logic known,
                               output word_t data);
      index_t s;
      tag_t   t;
      logic   way;
      s   = r.addr[OFFSET_W +: INDEX_W];
      t   = r.addr[ADDR_W-1 -: TAG_W];
      hit = 1'b1;
      if (m_valid[0][s] && m_tag[0][s] == t) begin
         way = 1'b0;
      end else if (m_valid[1][s] && m_tag[1][s] == t) begin
         way = 1'b1;
      end else begin
         hit = 1'b0;
         if (!m_valid[0][s]) begin
            way = 1'b0;
         end else if (!m_valid[1][s]) begin
            way = 1'b1;
         end else begin
            way = m_lru[s];
         end
      end
      m_valid[way][s] = 1'b1;
      m_tag[way][s]   = t;
      m_lru[s]        = ~way;   // Other way is now LRU
      if (r.wr) begin
         m_word[r.addr[ADDR_W-1:1]]  = r.data;
         m_known[r.addr[ADDR_W-1:1]] = 1'b1;
      end
      known = m_known[r.addr[ADDR_W-1:1]];
      data  = m_word[r.addr[ADDR_W-1:1]];
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("FAILED %s: data_out expected %h, actual %h", name, exp, act);
         err_count++;
      end
   endtask

   task automatic check_flag(input string name, input string what, input logic exp,
                             input logic act);
      if (act !== exp) begin
         $display("FAILED %s: %s expected %b, actual %b", name, what, exp, act);
         err_count++;
      end
   endtask

   task automatic run_entry(input int i);
      cache_req_t r;
      logic       m_hit;
      logic       m_known_w;
      word_t      m_data;
      logic       exp_hit;
      logic       got_done;
      logic       stall_gap;
      int         cycles;
      int         errs_before;
      r           = reqs[i];
      errs_before = err_count;
      cycles      = 0;
      got_done    = 1'b0;
      stall_gap   = 1'b0;
      m_hit       = 1'b0;
      m_known_w   = 1'b0;
      m_data      = '0;
      @(posedge clk);
      req <= r;
      while (!got_done && cycles < DONE_LIMIT) begin
         @(negedge clk);
         if (done) begin
            got_done = 1'b1;
         end else begin
            if (cycles > 0 && !stall) begin
               stall_gap = 1'b1;   // First cycle is the sampling cycle
            end
            cycles++;
         end
      end
      if (!got_done) begin
         $display("%s: done never came within %0d cycles", names[i], DONE_LIMIT);
         err_count++;
      end else begin
         if (stall_gap) begin
            $display("%s: stall went low before done", names[i]);
            err_count++;
         end
         if (!exp_errs[i]) begin
            model_access(r, m_hit, m_known_w, m_data);
            if (m_hit !== exp_hits[i]) begin
               $display("%s: table expects hit %b, model predicts %b", names[i],
                        exp_hits[i], m_hit);
               err_count++;
            end
         end
         exp_hit = exp_errs[i] ? 1'b0 : m_hit;
         check_flag(names[i], "err", exp_errs[i], err);
         check_flag(names[i], "cache_hit", exp_hit, cache_hit);
         if (r.rd && !r.wr && !exp_errs[i] && m_known_w) begin
            check_word(names[i], m_data, data_out);
         end
      end
      @(posedge clk);
      req <= '0;
      @(negedge clk);
      if (done || stall) begin
         $display("%s: done or stall still high the cycle after done", names[i]);
         err_count++;
      end
      if (err_count == errs_before) begin
         clean_count++;
         $display("%s: ok", names[i]);
      end else begin
         bad_count++;
         $display("%s: mismatch", names[i]);
      end
   endtask

   initial begin
      int unused_seed;
      arst_n      = 1'b0;
      req         = '0;
      table_ready = 1'b0;
      unused_seed = $urandom(59667);
      model_clear();
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check_flag("reset", "done", 1'b0, done);
      check_flag("reset", "stall", 1'b0, stall);
      check_flag("reset", "cache_hit", 1'b0, cache_hit);
      check_flag("reset", "err", 1'b0, err);
      for (int i = 0; i < reqs.size(); i++) begin
         run_entry(i);
      end
      $display("%0d entries: %0d clean, %0d with errors, %0d check errors in total",
               reqs.size(), clean_count, bad_count, err_count);
      if (err_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      int limit;
      wait (table_ready === 1'b1);
      limit = reqs.size() * WD_CYCLES * 2 * HALF_CLK;
      #(limit);
      $display("Watchdog expired after %0d time units, the run did not finish", limit);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire
